/* Bender.yml */
package:
  name: fsrc_tx

sources:
  - rtl/fsrc_pkg.sv
  - rtl/fsrc_cfg_regs.sv
  - rtl/fsrc_hole_gen.sv
  - rtl/fsrc_make_holes.sv
  - rtl/fsrc_tx_top.sv
  - target: simulation
    files:
      - bench/fsrc_tx_sva.sv
      - bench/tb_fsrc_tx.sv

/* bench/fsrc_tx_sva.sv */
/* Handshake stability assertions on the stream ports and the
   AXI4-Lite write response of the transmit top */

`timescale 1ns/1ps

module fsrc_tx_sva
  import fsrc_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      in_valid,
  input logic      in_ready,
  input bus_beat_t in_data,
  input logic      out_valid,
  input logic      out_ready,
  input bus_beat_t out_data,
  input logic      bvalid,
  input logic      bready
);

  // A stalled beat keeps valid and payload until it moves
  in_hold: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("input beat changed while stalled");

  out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output beat changed while stalled");

  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

bind fsrc_tx_top fsrc_tx_sva i_sva (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_data   (in_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .bvalid    (bvalid),
  .bready    (bready)
);

/* bench/tb_fsrc_tx.sv */
/* Testbench for the transmit converter with AXI4-Lite tasks, stream model,
   directed tests and watchdog */

`timescale 1ns/1ps

module tb_fsrc_tx
  import fsrc_pkg::*;
();

  localparam int BEATS_BYPASS    = 8;
  localparam int BEATS_FRAC      = 12;
  localparam int BEATS_BP        = 40;
  localparam int BEATS_CNT       = 10;
  localparam int WATCHDOG_CYCLES =
    200 * (BEATS_BYPASS + BEATS_FRAC + BEATS_BP + BEATS_CNT) + 2000;

  // Samples of one slot across all channels
  typedef sample_t [NUM_CHANNELS-1:0] slot_pair_t;

  logic       clk;
  logic       reset;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  logic       in_valid;
  logic       in_ready;
  bus_beat_t  in_data;
  logic       out_valid;
  logic       out_ready;
  bus_beat_t  out_data;

  integer     seed;
  logic       random_ready;
  hole_mask_t exp_masks[$];
  slot_pair_t exp_slots[$];
  sample_t    model_fill;
  int         beats_seen;

  fsrc_tx_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Error reporting and checks
  //////////////////////////////

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_reg(input string name, input axil_data_t exp, input axil_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_beat(input string name, input bus_beat_t exp, input bus_beat_t act);
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        if (act[ch][j] !== exp[ch][j]) begin
          stop_on_error($sformatf("mismatch %s[%0d][%0d]: expected %h, actual %h",
                                  name, ch, j, exp[ch][j], act[ch][j]));
        end
      end
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Carry on the j-th addition of step makes slot j a data slot
  function automatic hole_mask_t model_mask(inout logic [ACC_WIDTH-1:0] acc,
                                            input logic [ACC_WIDTH-1:0] st);
    logic [ACC_WIDTH:0] sum;
    hole_mask_t         m;
    m = '0;
    for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
      sum  = {1'b0, acc} + {1'b0, st};
      m[j] = !sum[ACC_WIDTH];
      acc  = sum[ACC_WIDTH-1:0];
    end
    return m;
  endfunction

  // Mask sequence for one run, the beats it yields and the holes transferred
  task automatic plan_masks(input logic en, input logic [ACC_WIDTH-1:0] st,
                            input int n_beats, output int n_out, output int n_holes);
    logic [ACC_WIDTH-1:0] acc;
    hole_mask_t           m;
    int                   used;
    int                   extra;
    logic                 full;
    acc     = '0;
    used    = 0;
    extra   = 0;
    full    = 1'b0;
    n_out   = 0;
    n_holes = 0;
    exp_masks.delete();
    // Two all-data masks already wait in the DUT when enable is set
    while (extra < 2) begin
      if (exp_masks.size() < 2 || !en) begin
        m = '0;
      end else begin
        m = model_mask(acc, st);
      end
      exp_masks.push_back(m);
      n_holes += $countones(m);
      if (!full && used + SAMPLES_PER_BEAT - $countones(m) <= SAMPLES_PER_BEAT * n_beats) begin
        used += SAMPLES_PER_BEAT - $countones(m);
        n_out++;
      end else begin
        full = 1'b1;
        extra++;
      end
    end
  endtask

  task automatic check_output_beat();
    hole_mask_t m;
    bus_beat_t  exp;
    slot_pair_t pair;
    if (exp_masks.size() == 0) begin
      stop_on_error("output beat appeared with no mask left in the model");
    end
    m = exp_masks.pop_front();
    for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
      if (m[j]) begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
          exp[ch][j] = model_fill;
        end
      end else begin
        if (exp_slots.size() == 0) begin
          stop_on_error("output beat needs more samples than were driven");
        end
        pair = exp_slots.pop_front();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
          exp[ch][j] = pair[ch];
        end
      end
    end
    check_beat("out_data", exp, out_data);
    beats_seen++;
  endtask

  // Output transfers are taken where out_valid and out_data are settled
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      check_output_beat();
    end
  end

  always @(posedge clk) begin
    #2;
    if (random_ready) begin
      out_ready = ({$random(seed)} % 3) != 0;
    end else begin
      out_ready = 1'b1;
    end
  end

  //////////////////////////////
  // Bus and stream tasks
  //////////////////////////////

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    exp_masks.delete();
    exp_slots.delete();
    beats_seen = 0;
    repeat (4) @(posedge clk);
    #2;
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b0;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_reg("bresp", axil_data_t'(RESP_OKAY), axil_data_t'(bresp));
    // Response waits one cycle before it is taken
    @(posedge clk);
    #2;
    bready = 1'b1;
    @(posedge clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    check_reg("rresp", axil_data_t'(RESP_OKAY), axil_data_t'(rresp));
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic send_beats(input int n, input logic gaps);
    bus_beat_t  beat;
    slot_pair_t pair;
    for (int b = 0; b < n; b++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
          beat[ch][j] = sample_t'($random(seed));
          pair[ch]    = beat[ch][j];
        end
        exp_slots.push_back(pair);
      end
      while (gaps && ({$random(seed)} % 3) == 0) begin
        @(posedge clk);
        #2;
      end
      in_valid = 1'b1;
      in_data  = beat;
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(posedge clk);
      #2;
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drain(input int n_out);
    while (beats_seen < n_out) @(negedge clk);
    repeat (30) @(negedge clk);
    if (beats_seen != n_out) begin
      stop_on_error("more output beats than the driven samples can fill");
    end
    @(posedge clk);
    #2;
  endtask

  task automatic configure(input logic [ACC_WIDTH-1:0] st, input sample_t fill,
                           input logic en);
    axil_write(REG_STEP, axil_data_t'(st));
    axil_write(REG_FILL, axil_data_t'(fill));
    axil_write(REG_CTRL, axil_data_t'(en));
    model_fill = fill;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_values();
    axil_data_t d;
    apply_reset();
    axil_read(REG_CTRL, d);
    check_reg("ctrl", 32'h0, d);
    axil_read(REG_STEP, d);
    check_reg("step", 32'h8000, d);
    axil_read(REG_FILL, d);
    check_reg("fill", 32'h0, d);
    axil_read(REG_HOLES, d);
    check_reg("holes", 32'h0, d);
    axil_write(REG_CTRL, 32'hFFFF_FFFF);
    axil_read(REG_CTRL, d);
    check_reg("ctrl", 32'h1, d);
    axil_write(REG_CTRL, 32'h0);
    axil_write(REG_STEP, 32'h0001_2345);
    axil_read(REG_STEP, d);
    check_reg("step", 32'h2345, d);
    axil_write(REG_FILL, 32'hA5A5_BEEF);
    axil_read(REG_FILL, d);
    check_reg("fill", 32'hBEEF, d);
    // Address between two registers
    axil_write(4'h6, 32'h1234_5678);
    axil_read(4'h6, d);
    check_reg("unmapped", 32'h0, d);
  endtask

  task automatic test_bypass();
    int n_out;
    int n_holes;
    apply_reset();
    model_fill = '0;
    plan_masks(1'b0, 16'h8000, BEATS_BYPASS, n_out, n_holes);
    send_beats(BEATS_BYPASS, 1'b0);
    wait_drain(n_out);
  endtask

  task automatic test_fractional();
    int n_out;
    int n_holes;
    apply_reset();
    configure(16'hC000, 16'hDEAD, 1'b1);
    plan_masks(1'b1, 16'hC000, BEATS_FRAC, n_out, n_holes);
    send_beats(BEATS_FRAC, 1'b0);
    wait_drain(n_out);
  endtask

  task automatic test_back_pressure();
    logic [ACC_WIDTH-1:0] st;
    int                   n_out;
    int                   n_holes;
    apply_reset();
    // Steps from 0x4000 up keep at least one data slot in every beat
    st = 16'h4000 + 16'({$random(seed)} % 32'hC000);
    configure(st, sample_t'($random(seed)), 1'b1);
    plan_masks(1'b1, st, BEATS_BP, n_out, n_holes);
    random_ready = 1'b1;
    send_beats(BEATS_BP, 1'b1);
    wait_drain(n_out);
    random_ready = 1'b0;
  endtask

  task automatic test_hole_counter();
    axil_data_t d;
    int         n_out;
    int         n_holes;
    apply_reset();
    configure(16'h5000, 16'h0BAD, 1'b1);
    plan_masks(1'b1, 16'h5000, BEATS_CNT, n_out, n_holes);
    send_beats(BEATS_CNT, 1'b0);
    wait_drain(n_out);
    axil_read(REG_HOLES, d);
    check_reg("holes", axil_data_t'(n_holes), d);
    axil_write(REG_HOLES, 32'h0);
    axil_read(REG_HOLES, d);
    check_reg("holes", 32'h0, d);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error("watchdog expired before the tests completed");
  end

  initial begin
    seed         = 77;
    clk          = 1'b0;
    reset        = 1'b1;
    random_ready = 1'b0;
    model_fill   = '0;
    beats_seen   = 0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    test_reset_values();
    test_bypass();
    test_fractional();
    test_back_pressure();
    test_hole_counter();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
rtl/fsrc_pkg.sv
rtl/fsrc_cfg_regs.sv
rtl/fsrc_hole_gen.sv
rtl/fsrc_make_holes.sv
rtl/fsrc_tx_top.sv
bench/fsrc_tx_sva.sv
bench/tb_fsrc_tx.sv

/* rtl/fsrc_cfg_regs.sv */
/* AXI4-Lite register block with control, step, fill value and
   hole-slot counter for the transmit converter */

`timescale 1ns/1ps

module fsrc_cfg_regs
  import fsrc_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  // Write channels
  input  axil_addr_t           awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  axil_data_t           wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,

  // Read channels
  input  axil_addr_t           araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output axil_data_t           rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready,

  // Hole counter updates from the mask generator
  input  logic                 hole_count_inc,
  input  logic [2:0]           hole_count_add,

  // Configuration outputs
  output logic                 enable,
  output logic [ACC_WIDTH-1:0] step,
  output sample_t              fill_value
);

  logic       wr_accept_q;
  logic       wr_en;
  logic       ar_xfer;
  axil_data_t hole_cnt_q;
  axil_data_t rd_mux;

  //////////////////////////////
  // Write path
  //////////////////////////////

  // One-cycle accept pulse once address and data are both present
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_accept_q <= 1'b0;
    end else begin
      wr_accept_q <= !wr_accept_q && awvalid && wvalid && !bvalid;
    end
  end

  assign awready = wr_accept_q;
  assign wready  = wr_accept_q;
  assign wr_en   = wr_accept_q && awvalid && wvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (wr_en) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign bresp = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable     <= 1'b0;
      step       <= STEP_RESET;
      fill_value <= '0;
    end else if (wr_en) begin
      case (awaddr)
        REG_CTRL: enable     <= wdata[0];
        REG_STEP: step       <= wdata[ACC_WIDTH-1:0];
        REG_FILL: fill_value <= wdata[SAMPLE_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Hole-slot counter cleared by any write to its address
  always_ff @(posedge clk) begin
    if (reset) begin
      hole_cnt_q <= '0;
    end else if (wr_en && awaddr == REG_HOLES) begin
      hole_cnt_q <= '0;
    end else if (hole_count_inc) begin
      hole_cnt_q <= hole_cnt_q + axil_data_t'(hole_count_add);
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  assign arready = !rvalid;
  assign ar_xfer = arvalid && arready;

  always_comb begin
    case (araddr)
      REG_CTRL:  rd_mux = axil_data_t'(enable);
      REG_STEP:  rd_mux = axil_data_t'(step);
      REG_FILL:  rd_mux = axil_data_t'(fill_value);
      REG_HOLES: rd_mux = hole_cnt_q;
      default:   rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (ar_xfer) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      rdata <= rd_mux;
    end
  end

  assign rresp = RESP_OKAY;

endmodule

/* rtl/fsrc_hole_gen.sv */
/* Phase accumulator producing one hole mask per beat
   and the hole-slot count of each transferred mask */

`timescale 1ns/1ps

module fsrc_hole_gen
  import fsrc_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic [ACC_WIDTH-1:0] step,

  output logic                 holes_valid,
  input  logic                 holes_ready,
  output hole_mask_t           holes_data,

  output logic                 hole_count_inc,
  output logic [2:0]           hole_count_add
);

  logic [ACC_WIDTH-1:0] acc_q;
  logic [ACC_WIDTH-1:0] acc_next;
  logic [ACC_WIDTH-1:0] phase;
  logic [ACC_WIDTH:0]   sum;
  logic [2:0]           num_holes;
  logic                 valid_q;
  logic                 holes_xfer;

  // Walk the beat one step per slot; a carry marks a data slot
  always_comb begin
    phase      = acc_q;
    sum        = '0;
    holes_data = '0;
    for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
      sum           = {1'b0, phase} + {1'b0, step};
      holes_data[j] = enable && !sum[ACC_WIDTH];
      phase         = sum[ACC_WIDTH-1:0];
    end
    acc_next = phase;
  end

  always_comb begin
    num_holes = '0;
    for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
      num_holes = num_holes + 3'(holes_data[j]);
    end
  end

  // Mask is offered in every cycle once out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  assign holes_valid = valid_q;
  assign holes_xfer  = holes_valid && holes_ready;

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      acc_q <= '0;
    end else if (holes_xfer) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hole_count_inc <= 1'b0;
    end else begin
      hole_count_inc <= holes_xfer;
    end
  end

  always_ff @(posedge clk) begin
    hole_count_add <= num_holes;
  end

endmodule

/* rtl/fsrc_make_holes.sv */
/* Hole inserter that spreads dense input samples over the data slots
   of each mask and puts the fill value into the hole slots */

`timescale 1ns/1ps

module fsrc_make_holes
  import fsrc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  logic       in_valid,
  output logic       in_ready,
  input  bus_beat_t  in_data,

  input  logic       holes_valid,
  output logic       holes_ready,
  input  hole_mask_t holes_data,

  output logic       out_valid,
  input  logic       out_ready,
  output bus_beat_t  out_data,

  input  sample_t    fill_value
);

  logic                                 active_q;
  logic                                 in_xfer;
  logic                                 holes_xfer;
  logic                                 out_xfer;

  // Skid stages
  logic                                 in_valid_q;
  bus_beat_t                            in_data_q;
  logic                                 mask_valid_q;
  hole_mask_t                           mask_q;

  // Mask stage with precomputed store positions
  logic [SAMPLES_PER_BEAT-1:0][SLOT_CNT_W-1:0] pos_cnt;
  logic [SAMPLES_PER_BEAT-1:0][SLOT_CNT_W-1:0] pos2_q;
  logic [SLOT_CNT_W-1:0]                       run_cnt;
  logic [SLOT_CNT_W-1:0]                       need2_q;
  hole_mask_t                                  mask2_q;
  logic                                        mask2_valid_q;
  logic                                        mask_adv;

  // Sample store with the oldest sample in slot 0
  sample_t [NUM_CHANNELS-1:0][STORE_SLOTS-1:0] store_q;
  sample_t [NUM_CHANNELS-1:0][STORE_SLOTS-1:0] store_next;
  logic [STORE_CNT_W-1:0]                      cnt_q;
  logic [STORE_CNT_W-1:0]                      cnt_next;
  logic [STORE_CNT_W-1:0]                      keep_cnt;
  logic [STORE_CNT_W-1:0]                      shift_cnt;
  logic                                        room_q;
  logic                                        append;
  logic                                        build;

  // Ready outputs stay low until the first cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  //////////////////////////////
  // Input and mask skid stages
  //////////////////////////////

  assign in_ready    = active_q && (!in_valid_q || append);
  assign in_xfer     = in_valid && in_ready;
  assign holes_ready = active_q && (!mask_valid_q || mask_adv);
  assign holes_xfer  = holes_valid && holes_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_valid_q   <= 1'b0;
      mask_valid_q <= 1'b0;
    end else begin
      if (in_xfer) begin
        in_valid_q <= 1'b1;
      end else if (append) begin
        in_valid_q <= 1'b0;
      end
      if (holes_xfer) begin
        mask_valid_q <= 1'b1;
      end else if (mask_adv) begin
        mask_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      in_data_q <= in_data;
    end
    if (holes_xfer) begin
      mask_q <= holes_data;
    end
  end

  // Running count of data slots up to and including each slot
  always_comb begin
    run_cnt = '0;
    for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
      run_cnt    = run_cnt + SLOT_CNT_W'(!mask_q[j]);
      pos_cnt[j] = run_cnt;
    end
  end

  assign mask_adv = mask_valid_q && (!mask2_valid_q || build);

  always_ff @(posedge clk) begin
    if (reset) begin
      mask2_valid_q <= 1'b0;
    end else if (mask_adv) begin
      mask2_valid_q <= 1'b1;
    end else if (build) begin
      mask2_valid_q <= 1'b0;
    end
  end

  // Counts become store indices by taking one off
  always_ff @(posedge clk) begin
    if (mask_adv) begin
      mask2_q <= mask_q;
      need2_q <= pos_cnt[SAMPLES_PER_BEAT-1];
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        pos2_q[j] <= pos_cnt[j] - 1'b1;
      end
    end
  end

  //////////////////////////////
  // Sample store
  //////////////////////////////

  assign build = mask2_valid_q && (cnt_q >= STORE_CNT_W'(need2_q)) && (!out_valid || out_ready);
  assign append = in_valid_q && room_q;

  assign shift_cnt = build ? STORE_CNT_W'(need2_q) : '0;
  assign keep_cnt  = cnt_q - shift_cnt;
  assign cnt_next  = keep_cnt + (append ? STORE_CNT_W'(SAMPLES_PER_BEAT) : '0);

  // Drop consumed samples, then append the new beat behind the rest
  always_comb begin
    store_next = store_q;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      for (int k = 0; k < STORE_SLOTS; k++) begin
        if (k < keep_cnt) begin
          store_next[ch][k] = store_q[ch][k + shift_cnt];
        end else if (append && k < keep_cnt + SAMPLES_PER_BEAT) begin
          store_next[ch][k] = in_data_q[ch][k - keep_cnt];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    store_q <= store_next;
  end

  // Room for a whole beat is judged on the count without pending shift-out
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q  <= '0;
      room_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_next;
      room_q <= cnt_next <= STORE_CNT_W'(2 * SAMPLES_PER_BEAT);
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  assign out_xfer = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (build) begin
      out_valid <= 1'b1;
    end else if (out_xfer) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (build) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
          out_data[ch][j] <= mask2_q[j] ? fill_value : store_q[ch][pos2_q[j]];
        end
      end
    end
  end

endmodule

/* rtl/fsrc_pkg.sv */
/* Sizes, sample and beat types, register map and reset values
   for the fractional sample-rate converter transmit path */

package fsrc_pkg;

  //////////////////////////////
  // Stream sizes
  //////////////////////////////

  localparam int NUM_CHANNELS     = 2;
  localparam int SAMPLES_PER_BEAT = 4;
  localparam int SAMPLE_WIDTH     = 16;
  localparam int ACC_WIDTH        = 16;

  // Sample store holds three beats per channel
  localparam int STORE_SLOTS = 3 * SAMPLES_PER_BEAT;

  // Counter widths for slots in one beat and samples in the store
  localparam int SLOT_CNT_W  = $clog2(SAMPLES_PER_BEAT + 1);
  localparam int STORE_CNT_W = $clog2(STORE_SLOTS + 1);

  typedef logic [SAMPLE_WIDTH-1:0]                  sample_t;
  typedef sample_t [SAMPLES_PER_BEAT-1:0]           chan_beat_t;
  typedef chan_beat_t [NUM_CHANNELS-1:0]            bus_beat_t;

  // Set bit marks a hole slot
  typedef logic [SAMPLES_PER_BEAT-1:0]              hole_mask_t;

  //////////////////////////////
  // Register interface
  //////////////////////////////

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  localparam axil_addr_t REG_CTRL  = 4'h0;
  localparam axil_addr_t REG_STEP  = 4'h4;
  localparam axil_addr_t REG_FILL  = 4'h8;
  localparam axil_addr_t REG_HOLES = 4'hC;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Half-rate pattern after reset
  localparam logic [ACC_WIDTH-1:0] STEP_RESET = 16'h8000;

endpackage

/* rtl/fsrc_tx_top.sv */
/* Transmit converter top with register block, hole-mask generator
   and hole inserter */

`timescale 1ns/1ps

module fsrc_tx_top
  import fsrc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // AXI4-Lite slave
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  // Dense sample input
  input  logic       in_valid,
  output logic       in_ready,
  input  bus_beat_t  in_data,

  // Output beats with holes
  output logic       out_valid,
  input  logic       out_ready,
  output bus_beat_t  out_data
);

  logic                 enable;
  logic [ACC_WIDTH-1:0] step;
  sample_t              fill_value;
  logic                 holes_valid;
  logic                 holes_ready;
  hole_mask_t           holes_data;
  logic                 hole_count_inc;
  logic [2:0]           hole_count_add;

  fsrc_cfg_regs i_cfg_regs (
    .clk            (clk),
    .reset          (reset),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .hole_count_inc (hole_count_inc),
    .hole_count_add (hole_count_add),
    .enable         (enable),
    .step           (step),
    .fill_value     (fill_value)
  );

  fsrc_hole_gen i_hole_gen (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .step           (step),
    .holes_valid    (holes_valid),
    .holes_ready    (holes_ready),
    .holes_data     (holes_data),
    .hole_count_inc (hole_count_inc),
    .hole_count_add (hole_count_add)
  );

  fsrc_make_holes i_make_holes (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .holes_valid (holes_valid),
    .holes_ready (holes_ready),
    .holes_data  (holes_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .fill_value  (fill_value)
  );

endmodule
